//--- source/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    typedef logic [10:0] mem_addr_t;    // 2 Kbyte array
    typedef logic [7:0]  mem_data_t;
    typedef logic [7:0]  ctrl_byte_t;
    typedef logic [3:0]  bit_idx_t;     // position inside a 9-bit frame

    localparam logic [3:0] DEVICE_CODE = 4'b1010;
    localparam int         QUARTERS    = 4;    // CLK cycles per SCL period

    typedef logic [$clog2(QUARTERS)-1:0] quarter_t;

    localparam quarter_t SAMPLE_QUARTER = quarter_t'(1);
    localparam quarter_t LAST_QUARTER   = quarter_t'(QUARTERS - 1);
    localparam bit_idx_t LAST_DATA_BIT  = 4'd7;
    localparam bit_idx_t ACK_SLOT       = 4'd8;

    typedef enum logic [2:0] {
        START,
        STOP,
        BIT0,
        BIT1,
        RELEASE     // line left to the slave for one bit
    } bit_sym_t;

    typedef struct packed {
        logic      wr;
        logic      rd;
        mem_addr_t addr;
        mem_data_t wr_data;
    } host_req_t;

    typedef struct packed {
        logic      done;
        logic      nack;
        mem_data_t rd_data;
    } host_resp_t;

    typedef struct packed {
        logic      byte_valid;
        mem_data_t data;
        logic      ack_valid;
        logic      ack_bit;
    } bus_sample_t;

endpackage

`default_nettype wire

//--- source/i2c_bit_tx.sv
`default_nettype none

module i2c_bit_tx
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  bit_sym_t sym,
    input  logic     sym_valid,
    output logic     sym_done,
    output logic     tx_idle,
    output logic     scl,
    output logic     scl_rise,
    output logic     sda_drive_low
);

    bit_sym_t            cur_sym;
    quarter_t            quarter;
    logic                busy;
    logic                accept;
    logic                data_sym;
    logic [QUARTERS-1:0] scl_shape;    // bit n is quarter n
    logic [QUARTERS-1:0] low_shape;

    // the next symbol may be taken in the last quarter, so symbols chain
    assign tx_idle = !busy || quarter == LAST_QUARTER;
    assign accept  = sym_valid && tx_idle;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            quarter  <= '0;
            sym_done <= 1'b0;
        end
        else
        begin
            sym_done <= busy && quarter == LAST_QUARTER;
            if (accept)
            begin
                busy    <= 1'b1;
                quarter <= '0;
            end
            else if (busy)
            begin
                quarter <= quarter + 1'b1;
                if (quarter == LAST_QUARTER)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            cur_sym <= sym;
    end

    // scl low, high, high, low for all but STOP
    // sda only moves in quarter 0 unless it is a START or STOP
    always_comb
    begin
        case (cur_sym)
            START:
            begin
                scl_shape = 4'b0110;
                low_shape = 4'b1100;    // falls while scl high
            end
            STOP:
            begin
                scl_shape = 4'b1110;    // leaves scl high
                low_shape = 4'b0011;    // rises while scl high
            end
            BIT0:
            begin
                scl_shape = 4'b0110;
                low_shape = 4'b1111;
            end
            default:
            begin
                scl_shape = 4'b0110;    // BIT1 and RELEASE
                low_shape = 4'b0000;
            end
        endcase
    end

    assign data_sym = cur_sym != START && cur_sym != STOP;

    // bus idles with both lines released
    assign scl           = busy ? scl_shape[quarter] : 1'b1;
    assign sda_drive_low = busy && low_shape[quarter];

    // only data bits are clocked into the receiver
    assign scl_rise = busy && data_sym && quarter == SAMPLE_QUARTER;

endmodule

`default_nettype wire

//--- source/i2c_byte_rx.sv
`default_nettype none

module i2c_byte_rx
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        scl_rise,
    input  logic        sda_in,
    input  logic        expect_byte,
    output bus_sample_t sample
);

    bit_idx_t  bit_cnt;
    logic      mode_q;
    mem_data_t shift_q;
    mem_data_t next_shift;

    assign next_shift = {shift_q[6:0], sda_in};    // msb first

    always_ff @(posedge CLK)
    begin
        if (scl_rise)
            shift_q <= next_shift;
    end

    // frames are nine bits; byte mode keeps the first eight, ack mode the ninth
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bit_cnt <= '0;
            mode_q  <= 1'b0;
            sample  <= '0;
        end
        else
        begin
            mode_q            <= expect_byte;
            sample.byte_valid <= 1'b0;
            sample.ack_valid  <= 1'b0;
            if (expect_byte != mode_q)
                bit_cnt <= '0;    // new frame type
            else if (scl_rise)
            begin
                bit_cnt <= (bit_cnt == ACK_SLOT) ? '0 : bit_cnt + 1'b1;
                if (mode_q && bit_cnt == LAST_DATA_BIT)
                begin
                    sample.byte_valid <= 1'b1;
                    sample.data       <= next_shift;
                end
                if (!mode_q && bit_cnt == ACK_SLOT)
                begin
                    sample.ack_valid <= 1'b1;
                    sample.ack_bit   <= sda_in;    // high means no ack
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/eeprom_sequencer.sv
`default_nettype none

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  host_req_t   req,
    input  logic        sym_done,
    input  logic        tx_idle,
    input  bus_sample_t sample,
    output bit_sym_t    sym,
    output logic        sym_valid,
    output logic        expect_byte,
    output host_resp_t  resp
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_START, ST_CTRL, ST_ADDR, ST_DATA_WR, ST_RESTART,
        ST_CTRL_RD, ST_DATA_RD, ST_MASTER_NACK, ST_STOP, ST_DONE
    } seq_state_t;

    seq_state_t state;
    seq_state_t byte_next;
    logic       rd_op;
    logic       strobe;
    logic       has_sym;
    logic       byte_state;
    logic       done_w;
    logic       expect_q;
    logic       nack_q;
    bit_idx_t   bit_cnt;
    mem_addr_t  addr_q;
    mem_data_t  wdata_q;
    mem_data_t  shift_q;
    mem_data_t  rd_data_q;

    function automatic ctrl_byte_t ctrl_byte(input mem_addr_t a, input logic rw);
        return {DEVICE_CODE, a[10:8], rw};    // block select in bits 3..1
    endfunction

    assign strobe     = req.wr || req.rd;
    assign byte_state = state inside {ST_CTRL, ST_ADDR, ST_DATA_WR, ST_CTRL_RD};

    always_comb
    begin
        has_sym = 1'b1;
        sym     = RELEASE;
        case (state)
            ST_START, ST_RESTART:
                sym = START;
            ST_CTRL, ST_ADDR, ST_DATA_WR, ST_CTRL_RD:
                if (bit_cnt != ACK_SLOT)
                    sym = shift_q[7] ? BIT1 : BIT0;
            ST_DATA_RD:
                sym = RELEASE;    // slave drives the data bits
            ST_MASTER_NACK:
                sym = BIT1;
            ST_STOP:
                sym = STOP;
            default:
                has_sym = 1'b0;
        endcase
    end

    assign sym_valid = has_sym && tx_idle;

    always_comb
    begin
        case (state)
            ST_CTRL:    byte_next = ST_ADDR;
            ST_ADDR:    byte_next = rd_op ? ST_RESTART : ST_DATA_WR;
            ST_CTRL_RD: byte_next = ST_DATA_RD;
            default:    byte_next = ST_STOP;
        endcase
    end

    // nothing is queued behind the stop, so tx_idle marks its own sym_done
    assign done_w = state == ST_DONE && sym_done && tx_idle;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            rd_op     <= 1'b0;
            bit_cnt   <= '0;
            expect_q  <= 1'b0;
            nack_q    <= 1'b0;
            rd_data_q <= '0;
        end
        else
        begin
            if (sample.ack_valid)
                nack_q <= nack_q | sample.ack_bit;    // a missing ack sticks
            if (sample.byte_valid)
                rd_data_q <= sample.data;
            case (state)
                ST_IDLE:
                    if (strobe)
                    begin
                        rd_op  <= !req.wr;    // write wins if both arrive
                        nack_q <= 1'b0;
                        state  <= ST_START;
                    end
                ST_START:
                    if (sym_valid)
                        state <= ST_CTRL;
                ST_RESTART:
                    if (sym_valid)
                        state <= ST_CTRL_RD;
                ST_CTRL, ST_ADDR, ST_DATA_WR, ST_CTRL_RD:
                    if (sym_valid)
                    begin
                        if (bit_cnt == ACK_SLOT)
                        begin
                            bit_cnt <= '0;
                            state   <= byte_next;
                        end
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                ST_DATA_RD:
                    if (sym_valid)
                    begin
                        // the ack of the read control byte is sampled by now
                        if (bit_cnt == '0)
                            expect_q <= 1'b1;
                        if (bit_cnt == LAST_DATA_BIT)
                        begin
                            bit_cnt <= '0;
                            state   <= ST_MASTER_NACK;
                        end
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                ST_MASTER_NACK:
                    if (sym_valid)
                        state <= ST_STOP;
                ST_STOP:
                    if (sym_valid)
                    begin
                        expect_q <= 1'b0;
                        state    <= ST_DONE;
                    end
                ST_DONE:
                    if (done_w)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // byte register, loaded ahead of each byte and shifted msb first
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && strobe)
        begin
            addr_q  <= req.addr;
            wdata_q <= req.wr_data;
        end
        if (sym_valid)
        begin
            if (state == ST_START || state == ST_RESTART)
                shift_q <= ctrl_byte(addr_q, state == ST_RESTART);
            else if (byte_state && bit_cnt == ACK_SLOT)
                shift_q <= (state == ST_CTRL) ? addr_q[7:0] : wdata_q;
            else if (byte_state)
                shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign expect_byte = expect_q;
    assign resp        = '{done: done_w, nack: nack_q, rd_data: rd_data_q};

endmodule

`default_nettype wire

//--- source/eeprom_ctrl.sv
`default_nettype none

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic      CLK,
    input  logic      RESET,
    input  logic      wr,
    input  logic      rd,
    input  mem_addr_t addr,
    input  mem_data_t wr_data,
    output logic      done,
    output logic      nack,
    output mem_data_t rd_data,
    output logic      scl,
    output logic      sda_drive_low,
    input  logic      sda_in
);

    host_req_t   req;
    host_resp_t  resp;
    bit_sym_t    sym;
    bus_sample_t sample;
    logic        sym_valid;
    logic        sym_done;
    logic        tx_idle;
    logic        scl_rise;
    logic        expect_byte;

    assign req = '{wr: wr, rd: rd, addr: addr, wr_data: wr_data};

    assign done    = resp.done;
    assign nack    = resp.nack;
    assign rd_data = resp.rd_data;

    i2c_bit_tx bit_tx_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .sym           (sym),
        .sym_valid     (sym_valid),
        .sym_done      (sym_done),
        .tx_idle       (tx_idle),
        .scl           (scl),
        .scl_rise      (scl_rise),
        .sda_drive_low (sda_drive_low)
    );

    // samples the resolved line, so it sees both master and slave bits
    i2c_byte_rx byte_rx_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl_rise    (scl_rise),
        .sda_in      (sda_in),
        .expect_byte (expect_byte),
        .sample      (sample)
    );

    eeprom_sequencer sequencer_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .req         (req),
        .sym_done    (sym_done),
        .tx_idle     (tx_idle),
        .sample      (sample),
        .sym         (sym),
        .sym_valid   (sym_valid),
        .expect_byte (expect_byte),
        .resp        (resp)
    );

endmodule

`default_nettype wire

//--- test/eeprom_model.sv
`default_nettype none

module eeprom_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,            // resolved open-drain line
    input  logic withhold_ack,
    output logic sda_drive_low
);

    typedef enum logic [2:0] {
        M_IDLE, M_DEV, M_ADDR, M_WDATA, M_RDATA
    } model_state_t;

    model_state_t state;
    model_state_t next_q;
    mem_data_t    mem [0:2047];
    logic         scl_q;
    logic         sda_q;
    logic [3:0]   bit_cnt;
    mem_data_t    shift_q;
    mem_data_t    out_q;
    logic [2:0]   block_q;
    mem_addr_t    ptr_q;
    logic         start_cond;
    logic         stop_cond;
    logic         scl_rise;
    logic         scl_fall;

    // a blank part reads all ones
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
    end

    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;
    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= M_IDLE;
            next_q        <= M_IDLE;
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            bit_cnt       <= '0;
            sda_drive_low <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (start_cond)
            begin
                state         <= M_DEV;
                bit_cnt       <= '0;
                sda_drive_low <= 1'b0;
            end
            else if (stop_cond)
            begin
                state         <= M_IDLE;
                sda_drive_low <= 1'b0;
            end
            else if (scl_rise && state != M_IDLE)
            begin
                if (bit_cnt < 4'd8)
                    shift_q <= {shift_q[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (scl_fall && state != M_IDLE)
            begin
                if (state == M_RDATA)
                begin
                    if (bit_cnt < 4'd8)
                    begin
                        sda_drive_low <= !out_q[7];
                        out_q         <= out_q << 1;
                    end
                    else
                        sda_drive_low <= 1'b0;    // master nack slot
                end
                else if (bit_cnt == 4'd8)
                begin
                    // byte complete, drive the ack during the ninth bit
                    sda_drive_low <= !withhold_ack;
                    next_q        <= M_IDLE;
                    case (state)
                        M_DEV:
                            if (shift_q[7:4] == DEVICE_CODE && !withhold_ack)
                            begin
                                block_q <= shift_q[3:1];
                                ptr_q   <= {shift_q[3:1], ptr_q[7:0]};
                                next_q  <= shift_q[0] ? M_RDATA : M_ADDR;
                            end
                            else
                                sda_drive_low <= 1'b0;
                        M_ADDR:
                            if (!withhold_ack)
                            begin
                                ptr_q  <= {block_q, shift_q};
                                next_q <= M_WDATA;
                            end
                        M_WDATA:
                            if (!withhold_ack)
                                mem[ptr_q] <= shift_q;
                        default:
                            sda_drive_low <= 1'b0;
                    endcase
                end
                else if (bit_cnt == 4'd9)
                begin
                    bit_cnt <= '0;
                    state   <= next_q;
                    if (next_q == M_RDATA)
                    begin
                        sda_drive_low <= !mem[ptr_q][7];    // first read bit
                        out_q         <= mem[ptr_q] << 1;
                    end
                    else
                        sda_drive_low <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/eeprom_ctrl_asserts.sv
`default_nettype none

module eeprom_ctrl_asserts
    import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     scl,
    input  logic     sda_drive_low,
    input  logic     done,
    input  logic     sym_valid,
    input  logic     tx_idle,
    input  bit_sym_t sym
);

    bit_sym_t last_sym;    // symbol on the bus right now

    always_ff @(posedge CLK)
    begin
        if (RESET)
            last_sym <= STOP;
        else if (sym_valid && tx_idle)
            last_sym <= sym;
    end

    property sda_steady_while_scl_high;
        @(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_drive_low != $past(sda_drive_low))
            |-> (last_sym == START || last_sym == STOP);
    endproperty

    property done_single_cycle;
        @(posedge CLK) disable iff (RESET)
        done |=> !done;
    endproperty

    // a symbol owns the transmitter for its first three quarters
    property accept_only_when_idle;
        @(posedge CLK) disable iff (RESET)
        sym_valid |-> !$past(sym_valid) && !$past(sym_valid, 2) && !$past(sym_valid, 3);
    endproperty

    assert property (sda_steady_while_scl_high)
        else $error("sda moved while scl high outside start or stop");
    assert property (done_single_cycle)
        else $error("done held longer than one cycle");
    assert property (accept_only_when_idle)
        else $error("symbol accepted before the previous one finished");

endmodule

bind eeprom_ctrl eeprom_ctrl_asserts asserts_inst (
    .CLK           (CLK),
    .RESET         (RESET),
    .scl           (scl),
    .sda_drive_low (sda_drive_low),
    .done          (done),
    .sym_valid     (sym_valid),
    .tx_idle       (tx_idle),
    .sym           (sym)
);

`default_nettype wire

//--- test/tb_eeprom_ctrl.sv
`default_nettype none

module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    localparam int WRITE_CYCLES = 116 + 2;
    localparam int READ_CYCLES  = 156 + 2;
    localparam int DONE_TIMEOUT = 400;

    typedef struct packed {
        logic      check_data;
        mem_data_t data;
        logic      nack;
    } expect_t;

    logic      CLK;
    logic      RESET;
    logic      wr;
    logic      rd;
    mem_addr_t addr;
    mem_data_t wr_data;
    logic      done;
    logic      nack;
    mem_data_t rd_data;
    logic      scl;
    logic      master_low;
    logic      model_low;
    logic      sda;
    logic      withhold_ack;

    mem_data_t ref_mem [0:2047];
    expect_t   exp_q [$];
    expect_t   cur_exp;
    int        data_errors;
    int        nack_errors;
    int        cycle_errors;
    int        other_errors;
    logic      aborted;

    assign sda = !(master_low || model_low);    // open drain with pull-up

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .wr            (wr),
        .rd            (rd),
        .addr          (addr),
        .wr_data       (wr_data),
        .done          (done),
        .nack          (nack),
        .rd_data       (rd_data),
        .scl           (scl),
        .sda_drive_low (master_low),
        .sda_in        (sda)
    );

    eeprom_model eeprom_model_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .withhold_ack  (withhold_ack),
        .sda_drive_low (model_low)
    );

    always #4 CLK = !CLK;

    // last byte written, FF where nothing was
    function automatic mem_data_t ref_access(input logic is_wr, input mem_addr_t a,
                                             input mem_data_t d);
        if (is_wr)
            ref_mem[a] = d;
        return ref_mem[a];
    endfunction

    task automatic check_data(input mem_data_t got, input mem_data_t exp);
        if (got !== exp)
        begin
            data_errors++;
            $display("** Error: rd_data = %h, expected %h", got, exp);
        end
    endtask

    task automatic check_nack(input logic got, input logic exp);
        if (got !== exp)
        begin
            nack_errors++;
            $display("** Error: nack = %h, expected %h", got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp);
        if (got != exp)
        begin
            cycle_errors++;
            $display("** Error: done latency = %h, expected %h", got, exp);
        end
    endtask

    // one transaction; stray puts a second strobe in the middle of it
    task automatic run_op(input logic is_wr, input mem_addr_t a, input mem_data_t d,
                          input logic no_ack, input logic stray);
        int      cycles;
        expect_t e;
        if (aborted)
            return;
        e.nack       = no_ack;
        e.check_data = !is_wr && !no_ack;
        e.data       = no_ack ? mem_data_t'(0) : ref_access(is_wr, a, d);
        exp_q.push_back(e);
        @(negedge CLK);
        withhold_ack = no_ack;
        wr           = is_wr;
        rd           = !is_wr;
        addr         = a;
        wr_data      = d;
        @(negedge CLK);
        wr     = 1'b0;
        rd     = 1'b0;
        cycles = 1;
        while (!done && cycles < DONE_TIMEOUT)
        begin
            wr = stray && cycles == 20;
            if (wr)
            begin
                addr    = ~a;
                wr_data = ~d;
            end
            @(negedge CLK);
            cycles++;
        end
        wr = 1'b0;
        if (!done)
        begin
            other_errors++;
            aborted = 1'b1;
            $display("timeout: no done pulse within %0d cycles of the strobe", DONE_TIMEOUT);
        end
        else
            check_cycles(cycles, is_wr ? WRITE_CYCLES : READ_CYCLES);
    endtask

    task automatic run_tests();
        mem_addr_t  a;
        mem_addr_t  b;
        mem_data_t  d;
        logic [2:0] flip;
        // blank reads
        run_op(1'b0, 11'h7FE, 8'h00, 1'b0, 1'b0);
        run_op(1'b0, 11'h000, 8'h00, 1'b0, 1'b0);
        run_op(1'b1, 11'h123, 8'h5A, 1'b0, 1'b0);
        run_op(1'b0, 11'h123, 8'h00, 1'b0, 1'b0);
        for (int i = 0; i < 20 && !aborted; i++)
        begin
            a    = mem_addr_t'($urandom);
            d    = mem_data_t'($urandom);
            flip = 3'($urandom_range(7, 1));
            b    = a ^ {flip, 8'h00};    // same word, other block
            run_op(1'b1, a, d, 1'b0, 1'b0);
            run_op(1'b1, b, ~d, 1'b0, 1'b0);
            run_op(1'b0, a, 8'h00, 1'b0, 1'b0);
            run_op(1'b0, b, 8'h00, 1'b0, 1'b0);
            run_op(1'b0, mem_addr_t'($urandom), 8'h00, 1'b0, 1'b0);
        end
        // slave keeps quiet
        run_op(1'b1, 11'h321, 8'hA5, 1'b1, 1'b0);
        run_op(1'b0, 11'h321, 8'h00, 1'b1, 1'b0);
        run_op(1'b0, 11'h321, 8'h00, 1'b0, 1'b0);
        run_op(1'b1, 11'h055, 8'hC3, 1'b0, 1'b1);
        run_op(1'b0, 11'h7AA, 8'h00, 1'b0, 1'b0);
        run_op(1'b0, 11'h055, 8'h00, 1'b0, 1'b0);
    endtask

    always @(negedge CLK)
    begin
        if (!RESET && done)
        begin
            if (exp_q.size() == 0)
            begin
                other_errors++;
                $display("done pulse arrived with no transaction outstanding");
            end
            else
            begin
                cur_exp = exp_q.pop_front();
                check_nack(nack, cur_exp.nack);
                if (cur_exp.check_data)
                    check_data(rd_data, cur_exp.data);
            end
        end
    end

    initial
    begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wr_data      = '0;
        withhold_ack = 1'b0;
        aborted      = 1'b0;
        data_errors  = 0;
        nack_errors  = 0;
        cycle_errors = 0;
        other_errors = 0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hFF;
        void'($urandom(84));
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        run_tests();
        repeat (4) @(negedge CLK);
        $display("errors: data %0d nack %0d latency %0d other %0d",
                 data_errors, nack_errors, cycle_errors, other_errors);
        if (data_errors + nack_errors + cycle_errors + other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- eeprom_ctrl.f
source/eeprom_pkg.sv
source/i2c_bit_tx.sv
source/i2c_byte_rx.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl.sv
test/eeprom_model.sv
test/eeprom_ctrl_asserts.sv
test/tb_eeprom_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_eeprom_ctrl
FILELIST  = eeprom_ctrl.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
